//--- src/uart_watch_pkg.sv
`default_nettype none

package uart_watch_pkg;

    localparam int BYTE_W     = 8;
    localparam int OVERSAMPLE = 16;
    localparam int REPORT_LEN = 11;

    // command bytes
    localparam logic [BYTE_W-1:0] CHAR_R = 8'h72;
    localparam logic [BYTE_W-1:0] CHAR_L = 8'h6c;
    localparam logic [BYTE_W-1:0] CHAR_U = 8'h75;
    localparam logic [BYTE_W-1:0] CHAR_D = 8'h64;
    localparam logic [BYTE_W-1:0] CHAR_S = 8'h73;

    // report characters
    localparam logic [BYTE_W-1:0] CHAR_ZERO  = 8'h30;
    localparam logic [BYTE_W-1:0] CHAR_COLON = 8'h3a;
    localparam logic [BYTE_W-1:0] CHAR_TICK  = 8'h27;

    typedef struct packed {
        logic btn_right;
        logic btn_left;
        logic btn_up;
        logic btn_down;
        logic send;
    } watch_cmd_t;

    typedef struct packed {
        logic [3:0] tens;
        logic [3:0] ones;
    } bcd2_t;

    // hour in the top byte, hundredths in the bottom byte
    typedef struct packed {
        bcd2_t hour;
        bcd2_t minute;
        bcd2_t second;
        bcd2_t centi;
    } watch_time_t;

endpackage

`default_nettype wire

//--- src/baud_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen #(
    parameter int CLK_HZ = 50_000_000,
    parameter int BAUD   = 312_500
) (
    input  logic clk,
    input  logic rst,
    output logic o_tick
);

    // clocks per oversampling tick
    localparam int DIV   = CLK_HZ / (BAUD * uart_watch_pkg::OVERSAMPLE);
    localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIV - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt    <= '0;
            o_tick <= 1'b0;
        end else if (cnt == CNT_LAST) begin
            cnt    <= '0;
            o_tick <= 1'b1;
        end else begin
            cnt    <= cnt + 1'b1;
            o_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/uart_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module uart_receiver (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_tick,
    input  logic                              i_rx,
    output logic [uart_watch_pkg::BYTE_W-1:0] o_data,
    output logic                              o_done
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    localparam int TICK_W = $clog2(uart_watch_pkg::OVERSAMPLE);
    localparam int BIT_W  = $clog2(uart_watch_pkg::BYTE_W);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(uart_watch_pkg::OVERSAMPLE - 1);
    localparam logic [TICK_W-1:0] TICK_HALF = TICK_W'(uart_watch_pkg::OVERSAMPLE / 2 - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(uart_watch_pkg::BYTE_W - 1);

    logic [1:0]                        state;
    logic [TICK_W-1:0]                 tick_cnt;
    logic [BIT_W-1:0]                  bit_cnt;
    logic [uart_watch_pkg::BYTE_W-1:0] shift_reg;

    assign o_data = shift_reg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                    // start edge seen on a tick
                    if (i_tick && !i_rx) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    // half a bit to reach mid-bit
                    if (i_tick) begin
                        if (tick_cnt == TICK_HALF) begin
                            tick_cnt <= '0;
                            state    <= S_DATA;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                S_DATA: begin
                    if (i_tick) begin
                        if (tick_cnt == TICK_LAST) begin
                            tick_cnt <= '0;
                            if (bit_cnt == BIT_LAST) begin
                                state <= S_STOP;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                S_STOP: begin
                    if (i_tick) begin
                        if (tick_cnt == TICK_LAST) begin
                            state  <= S_IDLE;
                            o_done <= 1'b1;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // lsb first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == S_DATA && i_tick && tick_cnt == TICK_LAST) begin
            shift_reg <= {i_rx, shift_reg[uart_watch_pkg::BYTE_W-1:1]};
        end
    end

endmodule

`default_nettype wire

//--- src/uart_transmitter.sv
`timescale 1ns/1ps
`default_nettype none

module uart_transmitter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_tick,
    input  logic                              i_start,
    input  logic [uart_watch_pkg::BYTE_W-1:0] i_data,
    output logic                              o_busy,
    output logic                              o_tx
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    localparam int TICK_W = $clog2(uart_watch_pkg::OVERSAMPLE);
    localparam int BIT_W  = $clog2(uart_watch_pkg::BYTE_W);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(uart_watch_pkg::OVERSAMPLE - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(uart_watch_pkg::BYTE_W - 1);

    logic [1:0]                        state;
    logic [TICK_W-1:0]                 tick_cnt;
    logic [BIT_W-1:0]                  bit_cnt;
    logic [uart_watch_pkg::BYTE_W-1:0] shift_reg;
    logic                              bit_end;

    assign bit_end = i_tick && (tick_cnt == TICK_LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_busy   <= 1'b0;
            o_tx     <= 1'b1;
        end else begin
            if (i_tick && state != S_IDLE) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                    o_tx     <= 1'b1;
                    if (i_start) begin
                        state  <= S_START;
                        o_busy <= 1'b1;
                        o_tx   <= 1'b0;
                    end
                end
                S_START: begin
                    if (bit_end) begin
                        state <= S_DATA;
                        o_tx  <= shift_reg[0];
                    end
                end
                S_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == BIT_LAST) begin
                            state <= S_STOP;
                            o_tx  <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            o_tx    <= shift_reg[1];
                        end
                    end
                end
                S_STOP: begin
                    // busy drops at the end of the stop bit
                    if (bit_end) begin
                        state  <= S_IDLE;
                        o_busy <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && i_start) begin
            shift_reg <= i_data;
        end else if (state == S_DATA && bit_end) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

`default_nettype wire

//--- src/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_push,
    input  logic [uart_watch_pkg::BYTE_W-1:0] i_data,
    input  logic                              i_pop,
    output logic [uart_watch_pkg::BYTE_W-1:0] o_data,
    output logic                              o_full,
    output logic                              o_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    logic [uart_watch_pkg::BYTE_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]                  wr_ptr;
    logic [PTR_W-1:0]                  rd_ptr;
    logic [CNT_W-1:0]                  count;
    logic                              wr_en;
    logic                              rd_en;

    assign o_full  = (count == CNT_FULL);
    assign o_empty = (count == '0);
    assign wr_en   = i_push && !o_full;
    assign rd_en   = i_pop && !o_empty;
    // head byte, valid whenever not empty
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/command_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module command_decoder (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_valid,
    input  logic [uart_watch_pkg::BYTE_W-1:0] i_data,
    output uart_watch_pkg::watch_cmd_t        o_cmd
);

    // one strobe per valid command byte, cleared the next cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_cmd <= '0;
        end else begin
            o_cmd <= '0;
            if (i_valid) begin
                case (i_data)
                    uart_watch_pkg::CHAR_R: o_cmd.btn_right <= 1'b1;
                    uart_watch_pkg::CHAR_L: o_cmd.btn_left  <= 1'b1;
                    uart_watch_pkg::CHAR_U: o_cmd.btn_up    <= 1'b1;
                    uart_watch_pkg::CHAR_D: o_cmd.btn_down  <= 1'b1;
                    uart_watch_pkg::CHAR_S: o_cmd.send      <= 1'b1;
                    default:                o_cmd           <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- src/time_reporter.sv
`timescale 1ns/1ps
`default_nettype none

module time_reporter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_send,
    input  uart_watch_pkg::watch_time_t       i_time,
    input  logic                              i_fifo_full,
    output logic                              o_push,
    output logic [uart_watch_pkg::BYTE_W-1:0] o_push_data
);

    localparam logic [1:0] S_IDLE    = 2'd0;
    localparam logic [1:0] S_CAPTURE = 2'd1;
    localparam logic [1:0] S_SENDING = 2'd2;

    localparam int IDX_W = $clog2(uart_watch_pkg::REPORT_LEN);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(uart_watch_pkg::REPORT_LEN - 1);

    logic [1:0]                        state;
    logic [IDX_W-1:0]                  idx;
    logic [uart_watch_pkg::BYTE_W-1:0] char_buf [uart_watch_pkg::REPORT_LEN];

    function automatic logic [uart_watch_pkg::BYTE_W-1:0] to_ascii(input logic [3:0] digit);
        return uart_watch_pkg::CHAR_ZERO + {4'b0000, digit};
    endfunction

    assign o_push      = (state == S_SENDING) && !i_fifo_full;
    assign o_push_data = char_buf[idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    idx <= '0;
                    if (i_send) begin
                        state <= S_CAPTURE;
                    end
                end
                S_CAPTURE: begin
                    state <= S_SENDING;
                end
                S_SENDING: begin
                    // stall while the tx fifo is full
                    if (!i_fifo_full) begin
                        if (idx == IDX_LAST) begin
                            state <= S_IDLE;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // HH:MM:SS'CC
    always_ff @(posedge clk) begin
        if (state == S_CAPTURE) begin
            char_buf[0]  <= to_ascii(i_time.hour.tens);
            char_buf[1]  <= to_ascii(i_time.hour.ones);
            char_buf[2]  <= uart_watch_pkg::CHAR_COLON;
            char_buf[3]  <= to_ascii(i_time.minute.tens);
            char_buf[4]  <= to_ascii(i_time.minute.ones);
            char_buf[5]  <= uart_watch_pkg::CHAR_COLON;
            char_buf[6]  <= to_ascii(i_time.second.tens);
            char_buf[7]  <= to_ascii(i_time.second.ones);
            char_buf[8]  <= uart_watch_pkg::CHAR_TICK;
            char_buf[9]  <= to_ascii(i_time.centi.tens);
            char_buf[10] <= to_ascii(i_time.centi.ones);
        end
    end

endmodule

`default_nettype wire

//--- src/uart_watch_link.sv
`timescale 1ns/1ps
`default_nettype none

module uart_watch_link #(
    parameter int CLK_HZ   = 50_000_000,
    parameter int BAUD     = 312_500,
    parameter int RX_DEPTH = 4,
    parameter int TX_DEPTH = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_uart_rx,
    input  uart_watch_pkg::watch_time_t i_time,
    output logic                        o_uart_tx,
    output uart_watch_pkg::watch_cmd_t  o_cmd
);

    logic                              tick;
    // receive path
    logic [uart_watch_pkg::BYTE_W-1:0] rx_data;
    logic                              rx_done;
    logic [uart_watch_pkg::BYTE_W-1:0] rx_fifo_data;
    logic                              rx_fifo_empty;
    logic                              rx_valid;
    // transmit path
    logic                              push;
    logic [uart_watch_pkg::BYTE_W-1:0] push_data;
    logic [uart_watch_pkg::BYTE_W-1:0] tx_fifo_data;
    logic                              tx_fifo_full;
    logic                              tx_fifo_empty;
    logic                              tx_start;
    logic                              tx_busy;
    logic                              tx_pop;

    // byte consumed in the cycle it is presented
    assign rx_valid = !rx_fifo_empty;
    assign tx_start = !tx_fifo_empty;
    assign tx_pop   = tx_start && !tx_busy;

    baud_tick_gen #(.CLK_HZ(CLK_HZ), .BAUD(BAUD)) baud_tick_gen_inst (
        .clk    (clk),
        .rst    (rst),
        .o_tick (tick)
    );

    uart_receiver uart_receiver_inst (
        .clk    (clk),
        .rst    (rst),
        .i_tick (tick),
        .i_rx   (i_uart_rx),
        .o_data (rx_data),
        .o_done (rx_done)
    );

    byte_fifo #(.DEPTH(RX_DEPTH)) rx_fifo_inst (
        .clk     (clk),
        .rst     (rst),
        .i_push  (rx_done),
        .i_data  (rx_data),
        .i_pop   (rx_valid),
        .o_data  (rx_fifo_data),
        .o_full  (),
        .o_empty (rx_fifo_empty)
    );

    command_decoder command_decoder_inst (
        .clk     (clk),
        .rst     (rst),
        .i_valid (rx_valid),
        .i_data  (rx_fifo_data),
        .o_cmd   (o_cmd)
    );

    time_reporter time_reporter_inst (
        .clk         (clk),
        .rst         (rst),
        .i_send      (o_cmd.send),
        .i_time      (i_time),
        .i_fifo_full (tx_fifo_full),
        .o_push      (push),
        .o_push_data (push_data)
    );

    byte_fifo #(.DEPTH(TX_DEPTH)) tx_fifo_inst (
        .clk     (clk),
        .rst     (rst),
        .i_push  (push),
        .i_data  (push_data),
        .i_pop   (tx_pop),
        .o_data  (tx_fifo_data),
        .o_full  (tx_fifo_full),
        .o_empty (tx_fifo_empty)
    );

    uart_transmitter uart_transmitter_inst (
        .clk     (clk),
        .rst     (rst),
        .i_tick  (tick),
        .i_start (tx_start),
        .i_data  (tx_fifo_data),
        .o_busy  (tx_busy),
        .o_tx    (o_uart_tx)
    );

endmodule

`default_nettype wire

//--- test/tb_uart_watch_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_watch_link;

    localparam int CLK_HZ   = 50_000_000;
    localparam int BAUD     = 312_500;
    // 160 clocks per bit
    localparam int BIT_CLKS = (CLK_HZ / (BAUD * uart_watch_pkg::OVERSAMPLE))
                              * uart_watch_pkg::OVERSAMPLE;

    localparam int N_SINGLE     = 4;
    localparam int N_NOISE      = 40;
    localparam int N_MIX        = 60;
    localparam int N_REPORTS    = 5;
    localparam int REPORT_CHARS = 11;
    localparam int N_SENT       = N_SINGLE + N_NOISE + N_MIX + N_REPORTS;
    localparam int N_RECV       = N_REPORTS * REPORT_CHARS;
    localparam int TIMEOUT_CYCLES = (N_SENT + N_RECV) * 10 * BIT_CLKS * 2;

    logic                        clk;
    logic                        rst;
    logic                        rx_line;
    uart_watch_pkg::watch_time_t time_in;
    logic                        tx_line;
    uart_watch_pkg::watch_cmd_t  cmd;

    int         error_count;
    int         act_cnt [5];
    int         exp_cnt [5];
    int         line_low_count;
    int         cycle_count;
    logic       report_started;
    logic [7:0] tx_bytes [$];

    // right, left, up, down in ascii
    logic [7:0] cmd_codes [4] = '{"r", "l", "u", "d"};
    string      strobe_names [5] = '{"right", "left", "up", "down", "send"};

    uart_watch_link #(
        .CLK_HZ   (CLK_HZ),
        .BAUD     (BAUD),
        .RX_DEPTH (4),
        .TX_DEPTH (16)
    ) uart_watch_link_inst (
        .clk       (clk),
        .rst       (rst),
        .i_uart_rx (rx_line),
        .i_time    (time_in),
        .o_uart_tx (tx_line),
        .o_cmd     (cmd)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("error %s: expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // start bit, 8 data bits lsb first, stop bit
    task send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx_line <= frame[i];
            repeat (BIT_CLKS) @(posedge clk);
        end
    endtask

    task settle_bits(input int n);
        repeat (n * BIT_CLKS) @(posedge clk);
    endtask

    task check_counts(input string name);
        for (int i = 0; i < 5; i++) begin
            check_value($sformatf("%s %s count", name, strobe_names[i]), exp_cnt[i], act_cnt[i]);
        end
    endtask

    task run_report(input int n);
        uart_watch_pkg::watch_time_t t;
        int    h;
        int    m;
        int    s;
        int    c;
        string exp_str;
        h = $urandom % 24;
        m = $urandom % 60;
        s = $urandom % 60;
        c = $urandom % 100;
        t.hour.tens   = h / 10;
        t.hour.ones   = h % 10;
        t.minute.tens = m / 10;
        t.minute.ones = m % 10;
        t.second.tens = s / 10;
        t.second.ones = s % 10;
        t.centi.tens  = c / 10;
        t.centi.ones  = c % 10;
        exp_str = $sformatf("%02d:%02d:%02d'%02d", h, m, s, c);
        time_in <= t;
        send_byte("s");
        exp_cnt[4]++;
        while (tx_bytes.size() < REPORT_CHARS) begin
            @(posedge clk);
        end
        // two frame times to catch any extra byte
        settle_bits(20);
        check_value($sformatf("report %0d length", n), REPORT_CHARS, tx_bytes.size());
        for (int i = 0; i < REPORT_CHARS; i++) begin
            check_value($sformatf("report %0d char %0d", n, i), exp_str[i], tx_bytes[i]);
        end
        check_counts($sformatf("report %0d", n));
        tx_bytes.delete();
    endtask

    // strobe counters sampled on the clock edge
    always @(posedge clk) begin
        if (!rst) begin
            if (cmd.btn_right) act_cnt[0]++;
            if (cmd.btn_left)  act_cnt[1]++;
            if (cmd.btn_up)    act_cnt[2]++;
            if (cmd.btn_down)  act_cnt[3]++;
            if (cmd.send)      act_cnt[4]++;
            if ($countones(cmd) > 1) begin
                error_count++;
                $display("more than one command strobe was high in the same cycle");
            end
            if (!report_started && tx_line !== 1'b1) begin
                line_low_count++;
            end
        end
    end

    // serial monitor sampling each bit near its middle
    always begin : tx_monitor
        logic [7:0] data;
        @(posedge clk);
        if (!rst && tx_line === 1'b0) begin
            repeat (BIT_CLKS / 2) @(posedge clk);
            if (tx_line !== 1'b0) begin
                error_count++;
                $display("start bit on o_uart_tx did not last to mid-bit");
            end
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(posedge clk);
                data[i] = tx_line;
            end
            repeat (BIT_CLKS) @(posedge clk);
            if (tx_line !== 1'b1) begin
                error_count++;
                $display("stop bit on o_uart_tx was not high");
            end
            tx_bytes.push_back(data);
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("closing: %0d errors", error_count + 1);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        logic [7:0] b;
        int         k;
        rst            = 1'b1;
        rx_line        = 1'b1;
        time_in        = '0;
        report_started = 1'b0;
        void'($urandom(63834));
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("reset tx idle", 1, tx_line);
        check_value("reset cmd", 0, cmd);

        // each button command alone
        for (int i = 0; i < N_SINGLE; i++) begin
            send_byte(cmd_codes[i]);
            exp_cnt[i]++;
            settle_bits(1);
            check_counts($sformatf("single %s", strobe_names[i]));
        end

        // bytes that decode to nothing with digits 0 to 2 first
        for (int i = 0; i < N_NOISE; i++) begin
            if (i < 3) begin
                b = 8'h30 + i[7:0];
            end else begin
                do begin
                    b = $urandom % 256;
                end while (b == "r" || b == "l" || b == "u" || b == "d" || b == "s");
            end
            send_byte(b);
        end
        settle_bits(1);
        check_counts("noise");

        // back to back mix
        for (int i = 0; i < N_MIX; i++) begin
            k = $urandom % 4;
            send_byte(cmd_codes[k]);
            exp_cnt[k]++;
        end
        settle_bits(1);
        check_counts("mix");
        check_value("tx idle before s", 0, line_low_count);
        check_value("bytes before s", 0, tx_bytes.size());

        report_started <= 1'b1;
        for (int n = 0; n < N_REPORTS; n++) begin
            run_report(n);
        end

        $display("closing: %0d errors", error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
src/uart_watch_pkg.sv
src/baud_tick_gen.sv
src/uart_receiver.sv
src/uart_transmitter.sv
src/byte_fifo.sv
src/command_decoder.sv
src/time_reporter.sv
src/uart_watch_link.sv
test/tb_uart_watch_link.sv
